/* Makefile */
# verilator build and run of the hub75 panel driver testbench

TOP := hub75_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

/* dv/hub75_tb.sv */
// ##################################################
// hub75 driver testbench
// random pixels, panel shift model and scan checks
// ##################################################
`timescale 1ns/100ps
`default_nettype none

module hub75_tb;

    import hub75_params_pkg::*;
    import hub75_types_pkg::*;

    localparam int          RESET_CYCLES = 10;
    localparam int          HOST_CYCLES  = 4;
    localparam int          ACK_LIMIT    = 8;
    localparam int          PIXEL_BITS   = $bits(pixel_word_t);
    localparam int          PLANE_BITS   = $clog2(PLANES);
    localparam logic [15:0] LFSR_SEED    = 16'd26099;
    // one frame past the row wrap, two on_unit values, then a resume
    localparam int FIRST_PLANES  = PLANES * PANEL_HALF_HEIGHT + 4;
    localparam int UNIT_PLANES   = 20;
    localparam int RESUME_PLANES = 10;
    localparam int IDLE_CYCLES   = 300;
    // on_unit stays at or below 32
    localparam int WORST_PLANE    = (32 << (PLANES - 1)) + PANEL_WIDTH + 16;
    localparam int TOTAL_PLANES   = FIRST_PLANES + 2 * UNIT_PLANES + RESUME_PLANES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + FB_DEPTH * HOST_CYCLES
                                  + TOTAL_PLANES * WORST_PLANE + IDLE_CYCLES + 1000;

    logic        clk_in;
    logic        reset = 1'b1;
    logic        req   = 1'b0;
    host_req_t   host  = '0;
    logic        ack;
    panel_pins_t pins;

    int          errors     = 0;
    int          checks     = 0;
    logic [15:0] lfsr_state = LFSR_SEED;
    pixel_word_t model_frame [FB_DEPTH];

    // panel model state
    logic                    monitor_on   = 1'b0;
    int                      cyc          = 0;
    logic                    pclk_last    = 1'b0;
    logic                    ack_last     = 1'b0;
    int                      shift_count  = 0;
    logic                    plane_open   = 1'b0;
    logic [5:0]              shifted [PANEL_WIDTH];
    logic [ROW_BITS-1:0]     exp_row      = '0;
    logic [PLANE_BITS-1:0]   exp_plane    = PLANE_BITS'(PLANES - 1);
    logic [ROW_BITS-1:0]     latched_row  = '0;
    int                      oe_left      = 0;
    int                      latch_count  = 0;
    logic                    enable_model = 1'b0;
    int                      disable_cyc  = 0;
    logic [ON_UNIT_BITS-1:0] unit_now     = ON_UNIT_BITS'(1);
    logic [ON_UNIT_BITS-1:0] unit_prev    = ON_UNIT_BITS'(1);

    hub75_top u_dut (
        .clk_in(clk_in),
        .reset (reset),
        .req   (req),
        .host  (host),
        .ack   (ack),
        .pins  (pins)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_in);
        $display("timeout: the scan did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks %0d, errors %0d", checks, errors);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("error %s: expected %0h, actual %0h", name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("failure: %s", msg);
        errors++;
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // colour order r0 g0 b0 r1 g1 b1
    function automatic logic [5:0] plane_bits(input logic [ROW_BITS-1:0] row,
                                              input logic [COL_BITS-1:0] col,
                                              input logic [PLANE_BITS-1:0] plane);
        pixel_word_t w;
        w = model_frame[{row, col}];
        return {w.r_top[plane], w.g_top[plane], w.b_top[plane],
                w.r_bot[plane], w.g_bot[plane], w.b_bot[plane]};
    endfunction

    // four-phase write, ack due on the 2nd edge after req
    task automatic host_write(input host_op_e op, input logic [FB_ADDR_BITS-1:0] addr,
                              input pixel_word_t data);
        int waited;
        @(negedge clk_in);
        host.op   = op;
        host.addr = addr;
        host.data = data;
        req       = 1'b1;
        waited    = 0;
        do begin
            @(negedge clk_in);
            waited++;
        end while (!ack && waited < ACK_LIMIT);
        checks++;
        if (!ack) begin
            report_failure("ack never rose after req");
        end else if (waited != 2) begin
            report_mismatch("ack_delay", 2, waited);
        end
        if (op == OP_PIXEL) begin
            model_frame[addr] = data;
        end
        req = 1'b0;
        @(negedge clk_in);
        checks++;
        if (ack) begin
            report_failure("ack still high one cycle after req dropped");
        end
    endtask

    task automatic wait_latches(input int count);
        int target;
        target = latch_count + count;
        while (latch_count < target) begin
            @(negedge clk_in);
        end
    endtask

    // end of a shifted plane
    task automatic check_latch();
        logic [COL_BITS-1:0] col;
        logic [5:0]          expected;
        checks++;
        if (!plane_open) begin
            report_failure("latch without a shifted plane");
        end else if (shift_count != PANEL_WIDTH) begin
            report_failure($sformatf("latch after %0d shifted columns", shift_count));
        end
        if (pins.row_addr != exp_row) begin
            report_mismatch("scan_row", int'(exp_row), int'(pins.row_addr));
        end
        for (int c = 0; c < PANEL_WIDTH; c++) begin
            col      = COL_BITS'(c);
            expected = plane_bits(exp_row, col, exp_plane);
            if (shifted[col] != expected) begin
                report_mismatch($sformatf("shift_data row %0d col %0d plane %0d",
                                          exp_row, c, exp_plane),
                                int'(expected), int'(shifted[col]));
            end
        end
        // window starts on the next cycle, with the unit seen at the internal latch
        oe_left     = int'(unit_prev) << exp_plane;
        latched_row = exp_row;
        plane_open  = 1'b0;
        latch_count++;
        // msb to lsb, then next row pair
        if (exp_plane == '0) begin
            exp_plane = PLANE_BITS'(PLANES - 1);
            if (exp_row == ROW_BITS'(PANEL_HALF_HEIGHT - 1)) begin
                exp_row = '0;
            end else begin
                exp_row = exp_row + ROW_BITS'(1);
            end
        end else begin
            exp_plane = exp_plane - PLANE_BITS'(1);
        end
    endtask

    // first ack cycle is the first with the new config
    task automatic track_config();
        if (host.op == OP_ENABLE) begin
            enable_model = host.data[0];
            disable_cyc  = cyc;
        end else if (host.op == OP_ON_UNIT) begin
            unit_now = host.data[ON_UNIT_BITS-1:0];
        end
    endtask

    task automatic sample_panel();
        logic [COL_BITS-1:0] col;
        cyc++;
        checks++;
        if (pins.oe_n != (oe_left == 0)) begin
            report_mismatch("oe_window", int'(oe_left == 0), int'(pins.oe_n));
        end
        if (!pins.oe_n && pins.row_addr != latched_row) begin
            report_mismatch("oe_row", int'(latched_row), int'(pins.row_addr));
        end
        if (pins.pixel_clk && !pclk_last) begin
            checks++;
            if (oe_left >= OVERLAP_CYCLES) begin
                report_failure($sformatf("pixel clock started with %0d oe cycles left",
                                         oe_left));
            end
            // a start already under way shows up 3 cycles after the config change
            if (!enable_model && cyc > disable_cyc + 3) begin
                report_failure("pixel clock started while the scan is disabled");
            end
            shift_count = 0;
            plane_open  = 1'b1;
        end
        if (pins.pixel_clk) begin
            if (shift_count < PANEL_WIDTH) begin
                col          = COL_BITS'(PANEL_WIDTH - 1 - shift_count);
                shifted[col] = {pins.r0, pins.g0, pins.b0, pins.r1, pins.g1, pins.b1};
            end
            shift_count++;
        end
        pclk_last = pins.pixel_clk;
        if (oe_left > 0) begin
            oe_left--;
        end
        if (pins.latch) begin
            check_latch();
        end
        if (ack && !ack_last) begin
            track_config();
        end
        ack_last  = ack;
        unit_prev = unit_now;
    endtask

    // mid high phase, gated pixel clock and registered pins settled
    initial begin
        forever begin
            @(posedge clk_in);
            #2;
            if (monitor_on) begin
                sample_panel();
            end
        end
    end

    initial begin
        logic [ON_UNIT_BITS-1:0] unit;
        int                      latches_before;
        repeat (RESET_CYCLES) @(negedge clk_in);
        reset      = 1'b0;
        monitor_on = 1'b1;
        for (int a = 0; a < FB_DEPTH; a++) begin
            host_write(OP_PIXEL, FB_ADDR_BITS'(a),
                       pixel_word_t'(PIXEL_BITS'(random_bits(PIXEL_BITS))));
        end
        host_write(OP_ENABLE, '0, pixel_word_t'(PIXEL_BITS'(1)));
        wait_latches(FIRST_PLANES);
        // new units land mid-scan
        repeat (2) begin
            unit = ON_UNIT_BITS'(random_bits(5)) + ON_UNIT_BITS'(1);
            host_write(OP_ON_UNIT, '0, pixel_word_t'(PIXEL_BITS'(unit)));
            wait_latches(UNIT_PLANES);
        end
        host_write(OP_ENABLE, '0, pixel_word_t'(PIXEL_BITS'(0)));
        latches_before = latch_count;
        repeat (IDLE_CYCLES) @(negedge clk_in);
        checks++;
        if (latch_count - latches_before > 1) begin
            report_failure("new latch after the scan was disabled");
        end
        host_write(OP_ENABLE, '0, pixel_word_t'(PIXEL_BITS'(1)));
        wait_latches(RESUME_PLANES);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
src/hub75_params_pkg.sv
src/hub75_types_pkg.sv
src/scan_timer.sv
src/brightness_timer.sv
src/matrix_scan.sv
src/frame_buffer.sv
src/scan_config_regs.sv
src/hub75_top.sv
dv/hub75_tb.sv

/* src/brightness_timer.sv */
// ##################################################
// brightness timer
// times each oe window from the active plane weight
// ##################################################
`timescale 1ns/100ps
`default_nettype none

module brightness_timer (
    input  logic                                      clk_in,
    input  logic                                      reset,
    input  logic                                      row_latch,
    input  logic [hub75_params_pkg::PLANES-1:0]       mask_active,
    input  logic [hub75_params_pkg::ON_UNIT_BITS-1:0] on_unit,
    output logic                                      oe,
    output logic                                      overlap
);

    import hub75_params_pkg::*;

    // remaining on-time, oe is high while non-zero
    logic [OE_COUNT_BITS-1:0] count;
    // window length for the plane being latched
    logic [OE_COUNT_BITS-1:0] load_value;

    // weight is 2^index of the set mask bit
    // mask is one-hot, all zero gives no window
    always_comb begin
        load_value = '0;
        for (int i = 0; i < PLANES; i++) begin
            if (mask_active[i]) begin
                load_value = OE_COUNT_BITS'(on_unit) << i;
            end
        end
    end

    // loaded on the latch cycle, so oe starts on the next one
    always_ff @(posedge clk_in) begin
        if (reset) begin
            count <= '0;
        end else if (row_latch) begin
            count <= load_value;
        end else if (oe) begin
            count <= count - OE_COUNT_BITS'(1);
        end
    end

    assign oe = (count != '0);

    // tail of the window, shifting of the next plane may begin
    assign overlap = oe && (count < OE_COUNT_BITS'(OVERLAP_CYCLES));

endmodule

`default_nettype wire

/* src/frame_buffer.sv */
// ##################################################
// frame buffer
// dual-port pixel memory, registered read
// ##################################################
`timescale 1ns/100ps
`default_nettype none

module frame_buffer (
    input  logic                                      clk_in,
    input  logic                                      we,
    input  logic [hub75_params_pkg::FB_ADDR_BITS-1:0] waddr,
    input  hub75_types_pkg::pixel_word_t              wdata,
    input  logic [hub75_params_pkg::FB_ADDR_BITS-1:0] raddr,
    output hub75_types_pkg::pixel_word_t              rdata
);

    import hub75_params_pkg::*;
    import hub75_types_pkg::*;

    // one word per column and row pair
    pixel_word_t mem [FB_DEPTH];

    // host write port
    always_ff @(posedge clk_in) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // scan read port
    // same-address collision returns the old word
    always_ff @(posedge clk_in) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* src/hub75_params_pkg.sv */
// ##################################################
// hub75 panel parameters
// geometry, bit-plane count and scan timing limits
// ##################################################
`default_nettype none

package hub75_params_pkg;

    // panel geometry with 16 rows per half
    localparam int PANEL_WIDTH       = 64;
    localparam int PANEL_HALF_HEIGHT = 16;
    localparam int COL_BITS          = 6;
    localparam int ROW_BITS          = 4;

    // binary-coded modulation depth per colour
    localparam int PLANES = 3;

    // on-time unit register width
    localparam int ON_UNIT_BITS = 8;

    // next plane may start shifting below this many oe cycles left
    localparam int OVERLAP_CYCLES = 8;

    // frame buffer holds one word per column and row pair
    localparam int FB_ADDR_BITS = ROW_BITS + COL_BITS;
    localparam int FB_DEPTH     = 1 << FB_ADDR_BITS;

    // column window timer counts to 64 and needs one extra bit
    localparam int COL_TIMER_BITS = COL_BITS + 1;

    // widest oe window is on_unit << (PLANES - 1)
    localparam int OE_COUNT_BITS = ON_UNIT_BITS + PLANES - 1;

    // first plane shifted after reset and after each lsb plane
    localparam logic [PLANES-1:0] MASK_MSB = PLANES'(1) << (PLANES - 1);

endpackage

`default_nettype wire

/* src/hub75_top.sv */
// ##################################################
// hub75 panel driver top
// config block, frame buffer and scan engine
// ##################################################
`timescale 1ns/100ps
`default_nettype none

module hub75_top (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         req,
    input  hub75_types_pkg::host_req_t   host,
    output logic                         ack,
    output hub75_types_pkg::panel_pins_t pins
);

    import hub75_params_pkg::*;
    import hub75_types_pkg::*;

    // host write path into the buffer
    logic                    fb_we;
    logic [FB_ADDR_BITS-1:0] fb_waddr;
    pixel_word_t             fb_wdata;

    // scan read path
    logic [FB_ADDR_BITS-1:0] rd_addr;
    pixel_word_t             rd_data;

    scan_cfg_t   cfg;
    panel_pins_t scan_pins;
    panel_pins_t pins_q;

    scan_config_regs u_config (
        .clk_in  (clk_in),
        .reset   (reset),
        .req     (req),
        .host    (host),
        .ack     (ack),
        .fb_we   (fb_we),
        .fb_waddr(fb_waddr),
        .fb_wdata(fb_wdata),
        .cfg     (cfg)
    );

    frame_buffer u_frame_buffer (
        .clk_in(clk_in),
        .we    (fb_we),
        .waddr (fb_waddr),
        .wdata (fb_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    matrix_scan u_scan (
        .clk_in (clk_in),
        .reset  (reset),
        .cfg    (cfg),
        .pixel  (rd_data),
        .rd_addr(rd_addr),
        .pins   (scan_pins)
    );

    // output register, pixel clock enable included so all pins line up
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pins_q <= PINS_IDLE;
        end else begin
            pins_q <= scan_pins;
        end
    end

    // gated pixel clock, the rest straight from the register
    always_comb begin
        pins           = pins_q;
        pins.pixel_clk = clk_in & pins_q.pixel_clk;
    end

endmodule

`default_nettype wire

/* src/hub75_types_pkg.sv */
// ##################################################
// hub75 shared types
// host request, pixel word, config and panel pins
// ##################################################
`default_nettype none

package hub75_types_pkg;

    // host opcodes
    typedef enum logic [1:0] {
        OP_PIXEL   = 2'd0,
        OP_ENABLE  = 2'd1,
        OP_ON_UNIT = 2'd2
    } host_op_e;

    // one frame buffer word, top half and bottom half of a column
    typedef struct packed {
        logic [hub75_params_pkg::PLANES-1:0] r_top;
        logic [hub75_params_pkg::PLANES-1:0] g_top;
        logic [hub75_params_pkg::PLANES-1:0] b_top;
        logic [hub75_params_pkg::PLANES-1:0] r_bot;
        logic [hub75_params_pkg::PLANES-1:0] g_bot;
        logic [hub75_params_pkg::PLANES-1:0] b_bot;
    } pixel_word_t;

    // addr is {row, column}
    // config ops carry their value in the low data bits
    typedef struct packed {
        host_op_e                                  op;
        logic [hub75_params_pkg::FB_ADDR_BITS-1:0] addr;
        pixel_word_t                               data;
    } host_req_t;

    typedef struct packed {
        logic                                      enable;
        logic [hub75_params_pkg::ON_UNIT_BITS-1:0] on_unit;
    } scan_cfg_t;

    typedef struct packed {
        logic                                  pixel_clk;
        logic                                  latch;
        logic                                  oe_n;
        logic [hub75_params_pkg::ROW_BITS-1:0] row_addr;
        logic                                  r0;
        logic                                  g0;
        logic                                  b0;
        logic                                  r1;
        logic                                  g1;
        logic                                  b1;
    } panel_pins_t;

    // scan stopped, unit of one cycle
    localparam scan_cfg_t CFG_RESET = '{
        enable:  1'b0,
        on_unit: (hub75_params_pkg::ON_UNIT_BITS)'(1)
    };

    // all pins inactive, leds off
    localparam panel_pins_t PINS_IDLE = '{
        pixel_clk: 1'b0,
        latch:     1'b0,
        oe_n:      1'b1,
        row_addr:  '0,
        r0:        1'b0,
        g0:        1'b0,
        b0:        1'b0,
        r1:        1'b0,
        g1:        1'b0,
        b1:        1'b0
    };

endpackage

`default_nettype wire

/* src/matrix_scan.sv */
// ##################################################
// matrix scan engine
// column shift, row latch, bit-plane mask, row address
// ##################################################
`timescale 1ns/100ps
`default_nettype none

module matrix_scan (
    input  logic                                      clk_in,
    input  logic                                      reset,
    input  hub75_types_pkg::scan_cfg_t                cfg,
    input  hub75_types_pkg::pixel_word_t              pixel,
    output logic [hub75_params_pkg::FB_ADDR_BITS-1:0] rd_addr,
    output hub75_types_pkg::panel_pins_t              pins
);

    import hub75_params_pkg::*;

    logic oe;
    logic overlap;

    // state advance request and its two-stage history
    logic       advance;
    logic [1:0] advance_sr;
    logic       start;
    // a plane is between its start and its latch
    logic       busy;

    logic                win_running;
    logic [COL_BITS-1:0] col_addr;
    // one cycle behind win_running, lines up with the buffer read
    logic                pixel_clk_en;

    // history of pixel_clk_en
    // [1:0] == 10 commits the shifted plane, [2:1] == 10 is the latch
    logic [2:0] latch_sr;
    logic       commit;
    logic       row_latch;

    // shifting copy feeds the buffer, active copy drives the leds
    logic [PLANES-1:0]   mask_shift;
    logic [PLANES-1:0]   mask_active;
    logic [ROW_BITS-1:0] row_shift;
    logic [ROW_BITS-1:0] row_active;

    // only start when idle or near the end of the current window
    assign advance = cfg.enable && !busy && (!oe || overlap);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            advance_sr <= 2'b00;
        end else begin
            advance_sr <= {advance_sr[0], advance};
        end
    end

    // rising edge of advance
    assign start = (advance_sr == 2'b01);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (row_latch) begin
            busy <= 1'b0;
        end
    end

    // 64 cycle column window
    scan_timer #(
        .WIDTH(COL_TIMER_BITS)
    ) u_col_window (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (start),
        .value  (COL_TIMER_BITS'(PANEL_WIDTH)),
        .count  (),
        .running(win_running)
    );

    // column address, 63 down to 0 in step with the window
    scan_timer #(
        .WIDTH(COL_BITS)
    ) u_col_addr (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (start),
        .value  (COL_BITS'(PANEL_WIDTH - 1)),
        .count  (col_addr),
        .running()
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixel_clk_en <= 1'b0;
            latch_sr     <= 3'b000;
        end else begin
            pixel_clk_en <= win_running;
            latch_sr     <= {latch_sr[1:0], pixel_clk_en};
        end
    end

    assign commit    = (latch_sr[1:0] == 2'b10);
    assign row_latch = (latch_sr[2:1] == 2'b10);

    // commit makes the shifted plane active, then steps to the next plane
    always_ff @(posedge clk_in) begin
        if (reset) begin
            mask_shift  <= MASK_MSB;
            mask_active <= '0;
            row_shift   <= '0;
            row_active  <= '0;
        end else if (commit) begin
            mask_active <= mask_shift;
            row_active  <= row_shift;
            if (mask_shift[0]) begin
                // lsb plane done, next row pair from the msb
                mask_shift <= MASK_MSB;
                if (row_shift == ROW_BITS'(PANEL_HALF_HEIGHT - 1)) begin
                    row_shift <= '0;
                end else begin
                    row_shift <= row_shift + ROW_BITS'(1);
                end
            end else begin
                mask_shift <= mask_shift >> 1;
            end
        end
    end

    // mask_active already holds the new plane on the latch cycle
    brightness_timer u_brightness (
        .clk_in     (clk_in),
        .reset      (reset),
        .row_latch  (row_latch),
        .mask_active(mask_active),
        .on_unit    (cfg.on_unit),
        .oe         (oe),
        .overlap    (overlap)
    );

    // {row, column} of the word being shifted
    assign rd_addr = {row_shift, col_addr};

    // one-hot mask picks the plane bit from each colour
    always_comb begin
        pins.pixel_clk = pixel_clk_en;
        pins.latch     = row_latch;
        pins.oe_n      = !oe;
        pins.row_addr  = row_active;
        pins.r0        = |(pixel.r_top & mask_shift);
        pins.g0        = |(pixel.g_top & mask_shift);
        pins.b0        = |(pixel.b_top & mask_shift);
        pins.r1        = |(pixel.r_bot & mask_shift);
        pins.g1        = |(pixel.g_bot & mask_shift);
        pins.b1        = |(pixel.b_bot & mask_shift);
    end

endmodule

`default_nettype wire

/* src/scan_config_regs.sv */
// ##################################################
// scan config registers
// four-phase host port, pixel writes and config
// ##################################################
`timescale 1ns/100ps
`default_nettype none

module scan_config_regs (
    input  logic                                      clk_in,
    input  logic                                      reset,
    input  logic                                      req,
    input  hub75_types_pkg::host_req_t                host,
    output logic                                      ack,
    output logic                                      fb_we,
    output logic [hub75_params_pkg::FB_ADDR_BITS-1:0] fb_waddr,
    output hub75_types_pkg::pixel_word_t              fb_wdata,
    output hub75_types_pkg::scan_cfg_t                cfg
);

    import hub75_params_pkg::*;
    import hub75_types_pkg::*;

    logic req_q;
    // first registered-high cycle of a request
    logic req_new;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req;
        end
    end

    assign req_new = req_q && !ack;

    // ack follows the write, drops the cycle after req does
    always_ff @(posedge clk_in) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (!req) begin
            ack <= 1'b0;
        end else if (req_new) begin
            ack <= 1'b1;
        end
    end

    // request is held stable while req is high
    assign fb_we    = req_new && (host.op == OP_PIXEL);
    assign fb_waddr = host.addr;
    assign fb_wdata = host.data;

    // config ops take their value from the low data bits
    always_ff @(posedge clk_in) begin
        if (reset) begin
            cfg <= CFG_RESET;
        end else if (req_new) begin
            case (host.op)
                OP_ENABLE:  cfg.enable  <= host.data[0];
                OP_ON_UNIT: cfg.on_unit <= host.data[ON_UNIT_BITS-1:0];
                default:    cfg         <= cfg;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/scan_timer.sv */
// ##################################################
// scan timer
// loadable down-counter with a running flag
// ##################################################
`timescale 1ns/100ps
`default_nettype none

module scan_timer #(
    parameter int WIDTH = 7
) (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             start,
    input  logic [WIDTH-1:0] value,
    output logic [WIDTH-1:0] count,
    output logic             running
);

    // load on start, then run down to zero and stay there
    // start wins over the decrement, so a restart reloads
    always_ff @(posedge clk_in) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= value;
        end else if (running) begin
            count <= count - WIDTH'(1);
        end
    end

    // high for exactly value cycles after the load
    assign running = (count != '0);

endmodule

`default_nettype wire
